// File: logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    parameter word_t     RESET_VECTOR_DEFAULT = 32'hbfc00000;
    parameter reg_addr_t REG_RA               = 5'd31;

    ////////////////////////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_SB      = 6'h28,
        OP_SW      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    ////////////////////////////////////////////////////////////
    // pipeline controls
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_SW, MEM_SB
    } mem_op_t;

    typedef enum logic [1:0] {
        PC_HOLD, PC_SEQ, PC_BRANCH, PC_JUMP
    } pc_sel_t;

    typedef enum logic [1:0] {
        FWD_NONE, FWD_MEM, FWD_WB
    } fwd_sel_t;

endpackage

`default_nettype wire

// File: logic/pipe_control.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_control (
    input  cpu_pkg::reg_addr_t id_rs,
    input  cpu_pkg::reg_addr_t id_rt,
    input  logic               id_valid,
    input  cpu_pkg::reg_addr_t ex_rs,
    input  cpu_pkg::reg_addr_t ex_rt,
    input  logic               ex_is_load,
    input  cpu_pkg::reg_addr_t ex_dest,
    input  logic               ex_redirect,
    input  cpu_pkg::reg_addr_t mem_dest,
    input  logic               mem_we,
    input  cpu_pkg::reg_addr_t wb_dest,
    input  logic               wb_we,
    output cpu_pkg::pc_sel_t   pc_sel,
    output logic               stall_front,
    output logic               squash_if,
    output logic               bubble_ex,
    output cpu_pkg::fwd_sel_t  fwd_a,
    output cpu_pkg::fwd_sel_t  fwd_b
);
    import cpu_pkg::*;

    logic load_use;

    // MEM is younger than WB so it wins, r0 is never a source
    function automatic fwd_sel_t pick_fwd(input reg_addr_t src);
        if (src != '0 && mem_we && mem_dest == src)
            return FWD_MEM;
        if (src != '0 && wb_we && wb_dest == src)
            return FWD_WB;
        return FWD_NONE;
    endfunction

    ////////////////////////////////////////////////////////////
    // hazards and next pc
    ////////////////////////////////////////////////////////////

    // ex_dest is zero whenever the EX entry writes nothing
    assign load_use = ex_is_load && id_valid && ex_dest != '0 &&
                      (ex_dest == id_rs || ex_dest == id_rt);

    assign stall_front = load_use;
    assign bubble_ex   = load_use;
    assign squash_if   = ex_redirect;    // delay slot sits in ID and survives

    always_comb begin
        if (load_use)
            pc_sel = PC_HOLD;
        else if (ex_redirect)
            pc_sel = PC_BRANCH;          // target already chosen in execute
        else
            pc_sel = PC_SEQ;
    end

    always_comb begin
        fwd_a = pick_fwd(ex_rs);
        fwd_b = pick_fwd(ex_rt);
    end

endmodule

`default_nettype wire

// File: logic/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
    parameter cpu_pkg::word_t RESET_VECTOR = cpu_pkg::RESET_VECTOR_DEFAULT
) (
    input  logic             clk,
    input  logic             resetn,
    input  cpu_pkg::pc_sel_t pc_sel,
    input  cpu_pkg::word_t   redirect_target,
    input  logic             stall_front,
    input  logic             squash_if,
    input  cpu_pkg::word_t   inst_rdata,
    output cpu_pkg::word_t   inst_addr,
    output cpu_pkg::word_t   if_pc,
    output cpu_pkg::word_t   if_instr,
    output logic             if_valid
);
    import cpu_pkg::*;

    word_t pc;

    assign inst_addr = pc;    // memory answers in the same cycle

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pc <= RESET_VECTOR;
        end else begin
            case (pc_sel)
                PC_SEQ:             pc <= pc + 32'd4;
                PC_BRANCH, PC_JUMP: pc <= redirect_target;
                default:            pc <= pc;    // hold
            endcase
        end
    end

    // IF/ID
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn)
            if_valid <= 1'b0;
        else if (!stall_front)
            if_valid <= !squash_if;
    end

    always_ff @(posedge clk) begin
        if (!stall_front) begin
            if_pc    <= pc;
            if_instr <= inst_rdata;
        end
    end

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic               clk,
    input  logic               resetn,
    input  cpu_pkg::word_t     if_pc,
    input  cpu_pkg::word_t     if_instr,
    input  logic               if_valid,
    input  logic               stall_front,
    input  logic               bubble_ex,
    input  cpu_pkg::word_t     rs_data,
    input  cpu_pkg::word_t     rt_data,
    output cpu_pkg::reg_addr_t id_rs,
    output cpu_pkg::reg_addr_t id_rt,
    output logic               id_valid,
    output cpu_pkg::word_t     ex_pc,
    output cpu_pkg::alu_op_t   ex_alu_op,
    output cpu_pkg::mem_op_t   ex_mem_op,
    output logic               ex_use_imm,
    output cpu_pkg::word_t     ex_imm,
    output logic [4:0]         ex_shamt,
    output cpu_pkg::reg_addr_t ex_dest,
    output logic               ex_we,
    output logic [1:0]         ex_branch,    // bit 0 beq, bit 1 bne
    output logic               ex_jump,
    output cpu_pkg::word_t     ex_rs_val,
    output cpu_pkg::word_t     ex_rt_val,
    output cpu_pkg::reg_addr_t ex_rs,
    output cpu_pkg::reg_addr_t ex_rt,
    output logic               ex_valid
);
    import cpu_pkg::*;

    opcode_t   opcode;
    funct_t    funct;
    logic [15:0] imm16;
    alu_op_t   alu_op;
    mem_op_t   mem_op;
    logic      use_imm, writes, we, jump, issue;
    logic [1:0] branch;
    word_t     imm;
    reg_addr_t dest;

    assign opcode   = opcode_t'(if_instr[31:26]);
    assign funct    = funct_t'(if_instr[5:0]);
    assign imm16    = if_instr[15:0];
    assign id_rs    = if_instr[25:21];
    assign id_rt    = if_instr[20:16];
    assign id_valid = if_valid;

    ////////////////////////////////////////////////////////////
    // decoder
    ////////////////////////////////////////////////////////////

    always_comb begin
        alu_op  = ALU_ADD;
        mem_op  = MEM_NONE;
        use_imm = 1'b1;
        imm     = {{16{imm16[15]}}, imm16};
        dest    = id_rt;
        writes  = 1'b1;
        branch  = 2'b00;
        jump    = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                use_imm = 1'b0;
                dest    = if_instr[15:11];
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    default: writes = 1'b0;    // unsupported, runs as a nop
                endcase
            end
            OP_ADDIU: alu_op = ALU_ADD;
            OP_SLTI:  alu_op = ALU_SLT;
            OP_SLTIU: alu_op = ALU_SLTU;
            OP_ANDI:  begin alu_op = ALU_AND; imm = {16'h0, imm16}; end
            OP_ORI:   begin alu_op = ALU_OR;  imm = {16'h0, imm16}; end
            OP_XORI:  begin alu_op = ALU_XOR; imm = {16'h0, imm16}; end
            OP_LUI:   begin alu_op = ALU_LUI; imm = {imm16, 16'h0}; end
            OP_LW:    mem_op = MEM_LW;
            OP_LB:    mem_op = MEM_LB;
            OP_LBU:   mem_op = MEM_LBU;
            OP_SW:    begin mem_op = MEM_SW; writes = 1'b0; end
            OP_SB:    begin mem_op = MEM_SB; writes = 1'b0; end
            OP_BEQ:   begin branch = 2'b01; writes = 1'b0; end
            OP_BNE:   begin branch = 2'b10; writes = 1'b0; end
            OP_J:     begin jump = 1'b1; writes = 1'b0; imm = {6'h0, if_instr[25:0]}; end
            OP_JAL:   begin jump = 1'b1; dest = REG_RA; imm = {6'h0, if_instr[25:0]}; end
            default:  writes = 1'b0;
        endcase
    end

    // r0 writes are dropped here, so downstream never sees dest 0 with we
    assign we    = writes && dest != '0;
    assign issue = if_valid && !bubble_ex;

    ////////////////////////////////////////////////////////////
    // ID/EX
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ex_valid  <= 1'b0;
            ex_we     <= 1'b0;
            ex_dest   <= '0;
            ex_mem_op <= MEM_NONE;
            ex_branch <= 2'b00;
            ex_jump   <= 1'b0;
        end else begin
            ex_valid  <= issue;
            ex_we     <= issue && we;
            ex_dest   <= (issue && we) ? dest : '0;
            ex_mem_op <= issue ? mem_op : MEM_NONE;
            ex_branch <= issue ? branch : 2'b00;
            ex_jump   <= issue && jump;
        end
    end

    // operands, only meaningful while ex_valid
    always_ff @(posedge clk) begin
        if (!stall_front) begin
            ex_pc      <= if_pc;
            ex_alu_op  <= alu_op;
            ex_use_imm <= use_imm;
            ex_imm     <= imm;
            ex_shamt   <= if_instr[10:6];
            ex_rs_val  <= rs_data;
            ex_rt_val  <= rt_data;
            ex_rs      <= id_rs;
            ex_rt      <= id_rt;
        end
    end

endmodule

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  logic               clk,
    input  logic               resetn,
    input  cpu_pkg::reg_addr_t ra0,
    input  cpu_pkg::reg_addr_t ra1,
    input  logic               we,
    input  cpu_pkg::reg_addr_t wa,
    input  cpu_pkg::word_t     wd,
    output cpu_pkg::word_t     rd0,
    output cpu_pkg::word_t     rd1
);
    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // write-through covers the WB to ID distance
    assign rd0 = (ra0 == '0) ? '0 : (we && wa == ra0) ? wd : regs[ra0];
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic               clk,
    input  logic               resetn,
    input  cpu_pkg::word_t     ex_pc,
    input  cpu_pkg::alu_op_t   ex_alu_op,
    input  cpu_pkg::mem_op_t   ex_mem_op,
    input  logic               ex_use_imm,
    input  cpu_pkg::word_t     ex_imm,
    input  logic [4:0]         ex_shamt,
    input  cpu_pkg::reg_addr_t ex_dest,
    input  logic               ex_we,
    input  logic [1:0]         ex_branch,
    input  logic               ex_jump,
    input  cpu_pkg::word_t     ex_rs_val,
    input  cpu_pkg::word_t     ex_rt_val,
    input  logic               ex_valid,
    input  cpu_pkg::fwd_sel_t  fwd_a,
    input  cpu_pkg::fwd_sel_t  fwd_b,
    input  cpu_pkg::word_t     mem_result,
    input  cpu_pkg::word_t     wb_data,
    output logic               ex_redirect,
    output cpu_pkg::word_t     redirect_target,
    output logic               ex_is_load,
    output cpu_pkg::word_t     mem_addr_raw,
    output cpu_pkg::word_t     mem_store_val,
    output cpu_pkg::mem_op_t   mem_op,
    output cpu_pkg::reg_addr_t mem_dest,
    output logic               mem_we,
    output cpu_pkg::word_t     mem_pc,
    output logic               mem_valid
);
    import cpu_pkg::*;

    word_t src_a, src_b, op_b, alu_y, slot_pc;
    logic  taken;

    // forwarding muxes
    assign src_a = (fwd_a == FWD_MEM) ? mem_result : (fwd_a == FWD_WB) ? wb_data : ex_rs_val;
    assign src_b = (fwd_b == FWD_MEM) ? mem_result : (fwd_b == FWD_WB) ? wb_data : ex_rt_val;
    assign op_b  = ex_use_imm ? ex_imm : src_b;

    always_comb begin
        case (ex_alu_op)
            ALU_SUB:  alu_y = src_a - op_b;
            ALU_AND:  alu_y = src_a & op_b;
            ALU_OR:   alu_y = src_a | op_b;
            ALU_XOR:  alu_y = src_a ^ op_b;
            ALU_NOR:  alu_y = ~(src_a | op_b);
            ALU_SLT:  alu_y = {31'd0, $signed(src_a) < $signed(op_b)};
            ALU_SLTU: alu_y = {31'd0, src_a < op_b};
            ALU_SLL:  alu_y = op_b << ex_shamt;
            ALU_SRL:  alu_y = op_b >> ex_shamt;
            ALU_SRA:  alu_y = word_t'($signed(op_b) >>> ex_shamt);
            ALU_LUI:  alu_y = op_b;    // immediate is already shifted up
            default:  alu_y = src_a + op_b;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // branch and jump resolution
    ////////////////////////////////////////////////////////////

    assign slot_pc = ex_pc + 32'd4;    // delay slot address
    assign taken   = (ex_branch[0] && src_a == src_b) || (ex_branch[1] && src_a != src_b);

    assign ex_redirect     = ex_valid && (taken || ex_jump);
    assign redirect_target = ex_jump ? {slot_pc[31:28], ex_imm[25:0], 2'b00}
                                     : slot_pc + {ex_imm[29:0], 2'b00};
    assign ex_is_load = ex_valid &&
                        (ex_mem_op == MEM_LW || ex_mem_op == MEM_LB || ex_mem_op == MEM_LBU);

    // EX/MEM
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
            mem_we    <= 1'b0;
            mem_op    <= MEM_NONE;
        end else begin
            mem_valid <= ex_valid;
            mem_we    <= ex_we;
            mem_op    <= ex_mem_op;
        end
    end

    always_ff @(posedge clk) begin
        mem_addr_raw  <= ex_jump ? ex_pc + 32'd8 : alu_y;    // jal link value
        mem_store_val <= src_b;
        mem_dest      <= ex_dest;
        mem_pc        <= ex_pc;
    end

endmodule

`default_nettype wire

// File: logic/memory_stage.sv
`timescale 1ns/10ps
`default_nettype none

module memory_stage (
    input  logic               clk,
    input  logic               resetn,
    input  cpu_pkg::word_t     mem_addr_raw,
    input  cpu_pkg::word_t     mem_store_val,
    input  cpu_pkg::mem_op_t   mem_op,
    input  cpu_pkg::reg_addr_t mem_dest,
    input  logic               mem_we,
    input  cpu_pkg::word_t     mem_pc,
    input  logic               mem_valid,
    input  cpu_pkg::word_t     data_rdata,
    output logic               data_en,
    output logic [3:0]         data_wen,
    output cpu_pkg::word_t     data_addr,
    output cpu_pkg::word_t     data_wdata,
    output cpu_pkg::word_t     mem_result,
    output logic               wb_we,
    output cpu_pkg::reg_addr_t wb_dest,
    output cpu_pkg::word_t     wb_data,
    output cpu_pkg::word_t     wb_pc
);
    import cpu_pkg::*;

    logic [7:0] load_byte;

    assign data_en   = mem_valid && mem_op != MEM_NONE;
    assign data_addr = {3'b000, mem_addr_raw[28:0]};    // kseg to physical

    ////////////////////////////////////////////////////////////
    // byte lanes, little endian
    ////////////////////////////////////////////////////////////

    always_comb begin
        data_wen = 4'b0000;
        if (mem_valid && mem_op == MEM_SW)
            data_wen = 4'b1111;
        else if (mem_valid && mem_op == MEM_SB)
            data_wen = 4'b0001 << mem_addr_raw[1:0];
    end

    // byte copied to every lane, strobe picks one
    assign data_wdata = (mem_op == MEM_SB) ? {4{mem_store_val[7:0]}} : mem_store_val;

    assign load_byte = data_rdata[{mem_addr_raw[1:0], 3'b000} +: 8];

    always_comb begin
        case (mem_op)
            MEM_LW:  mem_result = data_rdata;
            MEM_LB:  mem_result = {{24{load_byte[7]}}, load_byte};
            MEM_LBU: mem_result = {24'h0, load_byte};
            default: mem_result = mem_addr_raw;    // alu or link result
        endcase
    end

    // MEM/WB
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn)
            wb_we <= 1'b0;
        else
            wb_we <= mem_valid && mem_we;
    end

    always_ff @(posedge clk) begin
        wb_dest <= mem_dest;
        wb_data <= mem_result;
        wb_pc   <= mem_pc;
    end

endmodule

`default_nettype wire

// File: logic/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top #(
    parameter cpu_pkg::word_t RESET_VECTOR = cpu_pkg::RESET_VECTOR_DEFAULT
) (
    input  logic              clk,
    input  logic              resetn,
    // instruction port
    output cpu_pkg::word_t    inst_addr,
    input  cpu_pkg::word_t    inst_rdata,
    // data port
    output logic              data_en,
    output logic [3:0]        data_wen,
    output cpu_pkg::word_t    data_addr,
    output cpu_pkg::word_t    data_wdata,
    input  cpu_pkg::word_t    data_rdata,
    // debug writeback
    output cpu_pkg::word_t    debug_wb_pc,
    output logic [3:0]        debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t    debug_wb_rf_wdata
);
    import cpu_pkg::*;

    // IF/ID
    word_t     if_pc, if_instr;
    logic      if_valid;
    // decode side
    reg_addr_t id_rs, id_rt;
    logic      id_valid;
    word_t     rs_data, rt_data;
    // ID/EX
    word_t     ex_pc, ex_imm, ex_rs_val, ex_rt_val;
    alu_op_t   ex_alu_op;
    mem_op_t   ex_mem_op;
    logic      ex_use_imm, ex_we, ex_jump, ex_valid;
    logic [4:0] ex_shamt;
    logic [1:0] ex_branch;
    reg_addr_t ex_dest, ex_rs, ex_rt;
    // execute results
    logic      ex_redirect, ex_is_load;
    word_t     redirect_target;
    // EX/MEM
    word_t     mem_addr_raw, mem_store_val, mem_pc, mem_result;
    mem_op_t   mem_op;
    reg_addr_t mem_dest;
    logic      mem_we, mem_valid;
    // MEM/WB
    logic      wb_we;
    reg_addr_t wb_dest;
    word_t     wb_data, wb_pc;
    // control
    pc_sel_t   pc_sel;
    logic      stall_front, squash_if, bubble_ex;
    fwd_sel_t  fwd_a, fwd_b;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = {4{wb_we}};
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = wb_data;

    pipe_control u_ctrl (
        .id_rs, .id_rt, .id_valid, .ex_rs, .ex_rt, .ex_is_load, .ex_dest, .ex_redirect,
        .mem_dest, .mem_we, .wb_dest, .wb_we,
        .pc_sel, .stall_front, .squash_if, .bubble_ex, .fwd_a, .fwd_b
    );

    fetch_stage #(.RESET_VECTOR(RESET_VECTOR)) u_fetch (
        .clk, .resetn, .pc_sel, .redirect_target, .stall_front, .squash_if, .inst_rdata,
        .inst_addr, .if_pc, .if_instr, .if_valid
    );

    decode_stage u_decode (
        .clk, .resetn, .if_pc, .if_instr, .if_valid, .stall_front, .bubble_ex,
        .rs_data, .rt_data, .id_rs, .id_rt, .id_valid,
        .ex_pc, .ex_alu_op, .ex_mem_op, .ex_use_imm, .ex_imm, .ex_shamt, .ex_dest,
        .ex_we, .ex_branch, .ex_jump, .ex_rs_val, .ex_rt_val, .ex_rs, .ex_rt, .ex_valid
    );

    register_file u_rf (
        .clk, .resetn, .ra0(id_rs), .ra1(id_rt), .we(wb_we), .wa(wb_dest), .wd(wb_data),
        .rd0(rs_data), .rd1(rt_data)
    );

    execute_stage u_execute (
        .clk, .resetn, .ex_pc, .ex_alu_op, .ex_mem_op, .ex_use_imm, .ex_imm, .ex_shamt,
        .ex_dest, .ex_we, .ex_branch, .ex_jump, .ex_rs_val, .ex_rt_val, .ex_valid,
        .fwd_a, .fwd_b, .mem_result, .wb_data,
        .ex_redirect, .redirect_target, .ex_is_load,
        .mem_addr_raw, .mem_store_val, .mem_op, .mem_dest, .mem_we, .mem_pc, .mem_valid
    );

    memory_stage u_memory (
        .clk, .resetn, .mem_addr_raw, .mem_store_val, .mem_op, .mem_dest, .mem_we,
        .mem_pc, .mem_valid, .data_rdata,
        .data_en, .data_wen, .data_addr, .data_wdata, .mem_result,
        .wb_we, .wb_dest, .wb_data, .wb_pc
    );

endmodule

`default_nettype wire

// File: verif/cpu_checker.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_checker (
    input logic               clk,
    input logic               resetn,
    input logic               data_en,
    input logic [3:0]         data_wen,
    input logic [3:0]         debug_wb_rf_wen,
    input cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    input cpu_pkg::word_t     debug_wb_pc
);
    int   fail_count = 0;
    logic quiet, writing;

    assign quiet   = debug_wb_rf_wen == 4'h0 && !data_en && data_wen == 4'h0;
    assign writing = debug_wb_rf_wen != 4'h0;

    ////////////////////////////////////////////////////////////
    // port rules
    ////////////////////////////////////////////////////////////

    reset_quiet: assert property (@(posedge clk) (!resetn || !$past(resetn)) |-> quiet)
        else begin fail_count++; $error("strobe active in or just after reset"); end

    wen_needs_en: assert property (@(posedge clk) disable iff (!resetn)
        data_wen != 4'h0 |-> data_en)
        else begin fail_count++; $error("data_wen without data_en"); end

    no_r0_write: assert property (@(posedge clk) disable iff (!resetn)
        writing |-> debug_wb_rf_wnum != 5'd0)
        else begin fail_count++; $error("debug write to register 0"); end

    pc_aligned: assert property (@(posedge clk) disable iff (!resetn)
        writing |-> debug_wb_pc[1:0] == 2'b00)
        else begin fail_count++; $error("debug_wb_pc not word aligned"); end

endmodule

bind cpu_top cpu_checker u_checker (
    .clk(clk), .resetn(resetn), .data_en(data_en), .data_wen(data_wen),
    .debug_wb_rf_wen(debug_wb_rf_wen), .debug_wb_rf_wnum(debug_wb_rf_wnum),
    .debug_wb_pc(debug_wb_pc)
);

`default_nettype wire

// File: verif/tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam word_t PROG_BASE = 32'h00000400;

    logic clk, resetn;
    word_t inst_addr, inst_rdata, data_addr, data_wdata, data_rdata;
    word_t debug_wb_pc, debug_wb_rf_wdata;
    logic data_en;
    logic [3:0] data_wen, debug_wb_rf_wen;
    reg_addr_t debug_wb_rf_wnum;

    word_t imem [64];
    word_t dmem [64];
    word_t exp_pc [40];
    reg_addr_t exp_reg [40];
    word_t exp_val [40];
    word_t fetch_off;
    logic [5:0] load_idx;
    int exp_count, wb_idx, wb_errors, mem_errors, other_errors, cycles, limit;

    cpu_top #(.RESET_VECTOR(PROG_BASE)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycles++;

    ////////////////////////////////////////////////////////////
    // memory models
    ////////////////////////////////////////////////////////////

    always_comb begin
        fetch_off = inst_addr - PROG_BASE;
        inst_rdata = (fetch_off[31:8] == 24'h0) ? imem[fetch_off[7:2]] : 32'h0;    // nop outside
    end

    assign data_rdata = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (data_en) begin
            assert (data_addr[31:8] == 24'h0) else begin
                mem_errors++;
                $display("error: %0t data access at %h is outside the data memory", $time,
                         data_addr);
            end
            for (int b = 0; b < 4; b++)
                if (data_wen[b])
                    dmem[data_addr[7:2]][8*b +: 8] <= data_wdata[8*b +: 8];
        end
    end

    function automatic word_t fill_word(int i);
        word_t a;
        a = word_t'(i) << 2;
        return {a[15:0] ^ 16'h5a5a, a[15:0]};
    endfunction

    function automatic word_t enc_r(funct_t fn, int rs, int rt, int rd, int sh);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic word_t enc_j(opcode_t op, int index);
        return {op, index[25:0]};
    endfunction

    task automatic emit(word_t w);
        imem[load_idx] = w;
        load_idx = load_idx + 6'd1;
    endtask

    // instruction plus the writeback it must produce
    task automatic emit_with_wb(word_t w, word_t pc, int r, word_t v);
        emit(w);
        exp_pc[exp_count] = pc;
        exp_reg[exp_count] = r[4:0];
        exp_val[exp_count] = v;
        exp_count++;
    endtask

    task automatic check_mem(int idx, word_t v);
        assert (dmem[idx] == v) else begin
            mem_errors++;
            $display("error: %0t data word %0d is %h, expected %h", $time, idx, dmem[idx], v);
        end
    endtask

    // writebacks compared in the middle of the cycle
    always @(negedge clk) begin
        if (resetn && debug_wb_rf_wen != 4'h0) begin
            assert (debug_wb_rf_wen == 4'hf) else begin
                wb_errors++;
                $display("error: %0t debug write strobe is %b, expected 1111", $time,
                         debug_wb_rf_wen);
            end
            assert (wb_idx < exp_count) else begin
                wb_errors++;
                $display("error: %0t extra writeback pc %h r%0d", $time, debug_wb_pc,
                         debug_wb_rf_wnum);
            end
            if (wb_idx < exp_count) begin
                assert (debug_wb_pc == exp_pc[wb_idx] && debug_wb_rf_wnum == exp_reg[wb_idx]
                        && debug_wb_rf_wdata == exp_val[wb_idx]) else begin
                    wb_errors++;
                    $display("error: %0t writeback %0d got pc %h r%0d %h, expected pc %h r%0d %h",
                             $time, wb_idx, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                             exp_pc[wb_idx], exp_reg[wb_idx], exp_val[wb_idx]);
                end
                wb_idx++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // program and expected writebacks
    ////////////////////////////////////////////////////////////

    initial begin
        resetn = 1'b0;
        load_idx = '0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0;
            dmem[i] = fill_word(i);
        end
        // alu ops, 0x400
        emit_with_wb(enc_i(OP_ADDIU, 0, 1, 5), 32'h400, 1, 32'h5);
        emit_with_wb(enc_i(OP_ADDIU, 0, 2, 'hfffd), 32'h404, 2, 32'hfffffffd);
        emit_with_wb(enc_r(FN_ADDU, 1, 2, 3, 0), 32'h408, 3, 32'h2);
        emit_with_wb(enc_r(FN_SUBU, 3, 1, 4, 0), 32'h40c, 4, 32'hfffffffd);
        emit_with_wb(enc_r(FN_SLT, 2, 1, 5, 0), 32'h410, 5, 32'h1);
        emit_with_wb(enc_r(FN_SLTU, 2, 1, 6, 0), 32'h414, 6, 32'h0);
        emit_with_wb(enc_r(FN_AND, 1, 2, 7, 0), 32'h418, 7, 32'h5);
        emit_with_wb(enc_r(FN_OR, 1, 2, 8, 0), 32'h41c, 8, 32'hfffffffd);
        emit_with_wb(enc_r(FN_XOR, 1, 2, 9, 0), 32'h420, 9, 32'hfffffff8);
        emit_with_wb(enc_r(FN_NOR, 1, 2, 10, 0), 32'h424, 10, 32'h2);
        emit_with_wb(enc_r(FN_SLL, 0, 2, 11, 4), 32'h428, 11, 32'hffffffd0);
        emit_with_wb(enc_r(FN_SRL, 0, 2, 12, 28), 32'h42c, 12, 32'hf);
        emit_with_wb(enc_r(FN_SRA, 0, 2, 13, 1), 32'h430, 13, 32'hfffffffe);
        emit_with_wb(enc_i(OP_LUI, 0, 14, 'h8001), 32'h434, 14, 32'h80010000);
        emit_with_wb(enc_i(OP_ORI, 14, 15, 'h00ff), 32'h438, 15, 32'h800100ff);
        emit_with_wb(enc_i(OP_ANDI, 2, 16, 'hff00), 32'h43c, 16, 32'h0000ff00);
        emit_with_wb(enc_i(OP_XORI, 1, 17, 'hffff), 32'h440, 17, 32'h0000fffa);
        emit_with_wb(enc_i(OP_SLTI, 2, 18, 'hfffe), 32'h444, 18, 32'h1);
        emit_with_wb(enc_i(OP_SLTIU, 1, 19, 'hffff), 32'h448, 19, 32'h1);
        emit(enc_i(OP_ADDIU, 1, 0, 7));        // r0 target, no writeback
        emit_with_wb(enc_r(FN_ADDU, 0, 1, 20, 0), 32'h450, 20, 32'h5);
        // loads and stores, 0x454
        emit(enc_i(OP_SW, 0, 15, 16));
        emit(enc_i(OP_SB, 0, 1, 17));
        emit_with_wb(enc_i(OP_LW, 0, 21, 16), 32'h45c, 21, 32'h800105ff);
        emit_with_wb(enc_r(FN_ADDU, 21, 1, 22, 0), 32'h460, 22, 32'h80010604);
        emit_with_wb(enc_i(OP_LB, 0, 23, 16), 32'h464, 23, 32'hffffffff);
        emit_with_wb(enc_i(OP_LBU, 0, 24, 19), 32'h468, 24, 32'h00000080);
        emit_with_wb(enc_i(OP_LB, 0, 25, 17), 32'h46c, 25, 32'h00000005);
        emit_with_wb(enc_i(OP_LUI, 0, 26, 'ha000), 32'h470, 26, 32'ha0000000);
        emit(enc_i(OP_SW, 26, 3, 32));         // kseg1 address lands at 0x20
        // branches and jumps, 0x478
        emit(enc_i(OP_BEQ, 1, 20, 3));
        emit_with_wb(enc_i(OP_ADDIU, 0, 27, 1), 32'h47c, 27, 32'h1);
        emit(enc_i(OP_ADDIU, 0, 28, 'h77));
        emit(enc_i(OP_ADDIU, 0, 28, 'h66));
        emit(enc_i(OP_BNE, 1, 20, 5));
        emit_with_wb(enc_i(OP_ADDIU, 0, 28, 2), 32'h48c, 28, 32'h2);
        emit_with_wb(enc_i(OP_ADDIU, 0, 29, 3), 32'h490, 29, 32'h3);
        emit(enc_i(OP_BNE, 29, 28, 3));
        emit_with_wb(enc_i(OP_ADDIU, 27, 27, 1), 32'h498, 27, 32'h2);
        emit(enc_i(OP_ADDIU, 0, 30, 'h55));
        emit(enc_i(OP_ADDIU, 0, 30, 'h44));
        emit_with_wb(enc_j(OP_JAL, 'h12d), 32'h4a4, 31, 32'h4ac);
        emit_with_wb(enc_i(OP_ADDIU, 0, 30, 9), 32'h4a8, 30, 32'h9);
        emit(enc_i(OP_ADDIU, 0, 30, 'h11));
        emit(enc_i(OP_ADDIU, 0, 30, 'h22));
        emit_with_wb(enc_r(FN_ADDU, 31, 0, 29, 0), 32'h4b4, 29, 32'h4ac);
        emit(enc_j(OP_J, 'h131));
        emit(enc_i(OP_SW, 0, 29, 36));
        emit(enc_i(OP_ADDIU, 0, 30, 'h33));
        emit_with_wb(enc_i(OP_ADDIU, 30, 30, 1), 32'h4c4, 30, 32'ha);
        emit(enc_j(OP_J, 'h132));              // parks here, slot is a nop
        limit = exp_count * 5 + 50;

        repeat (5) @(posedge clk);
        #2 resetn = 1'b1;
        while (wb_idx < exp_count && cycles < limit)
            @(posedge clk);
        if (wb_idx < exp_count) begin
            other_errors++;
            $display("timeout: the program did not finish, %0d of %0d writebacks seen",
                     wb_idx, exp_count);
        end
        repeat (10) @(posedge clk);
        check_mem(4, 32'h800105ff);
        check_mem(5, fill_word(5));
        check_mem(8, 32'h00000002);
        check_mem(9, 32'h000004ac);
        $display("writeback errors %0d, memory errors %0d, checker failures %0d, other %0d",
                 wb_errors, mem_errors, UUT.u_checker.fail_count, other_errors);
        if (wb_errors + mem_errors + other_errors + UUT.u_checker.fail_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
logic/cpu_pkg.sv
logic/pipe_control.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/register_file.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_top.sv
verif/cpu_checker.sv
verif/tb_cpu.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f sources.f --top-module tb_cpu -o vtb_cpu
	./obj_dir/vtb_cpu | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir
